//--- verilog.f
hw/cmdout_pkg.sv
hw/cmdout_mem.sv
hw/cmdout_scanner.sv
hw/finish_tracker.sv
hw/cmdout_unit.sv
dv/cmdout_chk.sv
dv/tb_cmdout.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cmdout
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the verdict comes from the printed pass line, the run output is shown as it goes
test: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_cmdout.sv
`timescale 1ns/1ps

module tb_cmdout;

    import cmdout_pkg::*;

    localparam int NUM_ACCS = 16;
    localparam int SLOT_W = 6;
    localparam int MAX_TASKS = 256;
    localparam int SCAN_BOUND = 2 * NUM_ACCS + 4;

    logic        clk;
    logic        rst;
    acc_write_t  acc_wr;
    finish_t     done;
    logic [31:0] finished_count;
    logic        dup_error;
    logic        range_error;

    int seed = 45203;
    int errors = 0;
    int test_start_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    // model of each ring's next free slot and of the indices handed out
    logic [SLOT_W-1:0] ring_slot [NUM_ACCS];
    bit                used_idx [MAX_TASKS];
    bit                posted_set [MAX_TASKS];
    bit                reported [MAX_TASKS];
    logic [DATA_W-1:0] done_q [$];
    logic [DATA_W-1:0] exp_q [$];

    cmdout_unit #(
        .NUM_ACCS  (NUM_ACCS),
        .SLOT_W    (SLOT_W),
        .MAX_TASKS (MAX_TASKS)
    ) dut0 (
        .clk            (clk),
        .rst            (rst),
        .acc_wr         (acc_wr),
        .done           (done),
        .finished_count (finished_count),
        .dup_error      (dup_error),
        .range_error    (range_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (done.strobe) begin
            done_q.push_back(done.tid);
        end
    end

    initial begin
        #1_000_000;
        $display("simulation ran too long and was stopped");
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("[ERROR] %0t %s", $time, what);
        errors++;
    endtask

    function automatic logic [TASK_IDX_W-1:0] pick_index();
        int idx;
        idx = int'($unsigned($random(seed)) % MAX_TASKS);
        while (used_idx[idx]) begin
            idx = (idx + 1) % MAX_TASKS;
        end
        used_idx[idx] = 1'b1;
        return TASK_IDX_W'(idx);
    endfunction

    // task-id word first, header last, so a valid header always has its id behind it
    task automatic post_entry(input int acc, input logic [TASK_IDX_W-1:0] idx);
        logic [ADDR_W-1:0] base;
        logic [DATA_W-1:0] word;
        base = ADDR_W'((acc << SLOT_W) + int'(ring_slot[acc]));
        word = {8'h5a, idx, 32'($random(seed))};
        exp_q.push_back(word);
        @(posedge clk);
        acc_wr.strobe <= 1'b1;
        acc_wr.addr <= base + ADDR_W'(1);
        acc_wr.data <= word;
        @(posedge clk);
        acc_wr.addr <= base;
        acc_wr.data <= {VALID_MARK, 48'h0, 8'(acc)};
        @(posedge clk);
        acc_wr.strobe <= 1'b0;
        ring_slot[acc] = ring_slot[acc] + SLOT_W'(2);
    endtask

    task automatic wait_reports(input int count, input int limit);
        int cycles;
        cycles = 0;
        while (done_q.size() < count && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (done_q.size() < count) begin
            report_problem($sformatf("no done report after %0d cycles, expected %0d, saw %0d",
                                     limit, count, done_q.size()));
        end
    endtask

    task automatic compare_reports();
        check_value("done report count", 64'(done_q.size()), 64'(exp_q.size()));
        for (int i = 0; i < exp_q.size() && i < done_q.size(); i++) begin
            check_value($sformatf("done.tid[%0d]", i), done_q[i], exp_q[i]);
        end
    endtask

    // a collected entry leaves its header without the valid mark
    task automatic check_header_cleared(input int acc, input int slot);
        check_value($sformatf("header[%0d][%0d] valid byte", acc, slot),
                    64'(dut0.u_mem.mem[(acc << SLOT_W) + slot][63:56]), 64'h0);
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        done_q.delete();
        exp_q.delete();
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_start_errors);
        end
    endtask

    initial begin
        int base_count;
        int first_slot;
        int ri;
        logic [TASK_IDX_W-1:0] idx;
        rst = 1'b1;
        acc_wr = '0;
        for (int i = 0; i < NUM_ACCS; i++) begin
            ring_slot[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        begin_test();
        post_entry(3, pick_index());
        wait_reports(1, SCAN_BOUND);
        repeat (2 * NUM_ACCS) @(negedge clk);
        compare_reports();
        check_value("finished_count", 64'(finished_count), 64'd1);
        end_test("single post");

        begin_test();
        base_count = int'(finished_count);
        first_slot = int'(ring_slot[7]);
        for (int n = 0; n < 3; n++) begin
            post_entry(7, pick_index());
        end
        wait_reports(3, 3 * SCAN_BOUND);
        // a full extra sweep must bring no further report
        repeat (3 * NUM_ACCS) @(negedge clk);
        compare_reports();
        for (int n = 0; n < 3; n++) begin
            check_header_cleared(7, (first_slot + 2 * n) % (1 << SLOT_W));
        end
        check_value("finished_count", 64'(finished_count), 64'(base_count + 3));
        end_test("ring advance and clear");

        // posting under reset keeps the scanner parked at accelerator 0
        begin_test();
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < NUM_ACCS; i++) begin
            ring_slot[i] = '0;
        end
        post_entry(2, pick_index());
        post_entry(5, pick_index());
        post_entry(9, pick_index());
        post_entry(14, pick_index());
        rst <= 1'b0;
        wait_reports(4, 2 * SCAN_BOUND);
        repeat (2 * NUM_ACCS) @(negedge clk);
        compare_reports();
        check_value("finished_count", 64'(finished_count), 64'd4);
        end_test("round robin");

        begin_test();
        base_count = int'(finished_count);
        for (int n = 0; n < 40; n++) begin
            idx = pick_index();
            posted_set[idx] = 1'b1;
            post_entry(int'($unsigned($random(seed)) % NUM_ACCS), idx);
        end
        wait_reports(40, 40 * SCAN_BOUND);
        repeat (2 * NUM_ACCS) @(negedge clk);
        check_value("done report count", 64'(done_q.size()), 64'd40);
        foreach (done_q[i]) begin
            ri = int'(done_q[i][TASK_IDX_LSB +: TASK_IDX_W]);
            assert (ri < MAX_TASKS && posted_set[ri] && !reported[ri]) else begin
                report_problem($sformatf("index %0d reported but never posted or seen twice", ri));
            end
            if (ri < MAX_TASKS) begin
                reported[ri] = 1'b1;
            end
        end
        check_value("finished_count", 64'(finished_count), 64'(base_count + 40));
        check_value("dup_error", 64'(dup_error), 64'd0);
        check_value("range_error", 64'(range_error), 64'd0);
        end_test("random load");

        begin_test();
        base_count = int'(finished_count);
        post_entry(11, idx);
        wait_reports(1, SCAN_BOUND);
        compare_reports();
        check_value("dup_error", 64'(dup_error), 64'd1);
        check_value("finished_count", 64'(finished_count), 64'(base_count));
        end_test("duplicate");

        begin_test();
        base_count = int'(finished_count);
        post_entry(6, TASK_IDX_W'(MAX_TASKS + int'($unsigned($random(seed)) % 1000)));
        wait_reports(1, SCAN_BOUND);
        compare_reports();
        check_value("range_error", 64'(range_error), 64'd1);
        check_value("finished_count", 64'(finished_count), 64'(base_count));
        end_test("out of range");

        errors = errors + dut0.chk0.fail_count;
        $display("tests passed %0d, failed %0d, bound assertion failures %0d",
                 tests_passed, tests_failed, dut0.chk0.fail_count);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- dv/cmdout_chk.sv
`timescale 1ns/1ps

module cmdout_chk (
    input logic                clk,
    input logic                rst,
    input cmdout_pkg::mem_req_t scan_req,
    input cmdout_pkg::finish_t finish,
    input cmdout_pkg::finish_t done,
    input logic [31:0]         finished_count
);

    import cmdout_pkg::*;

    int fail_count = 0;

    // the scanner writes only to clear the valid byte of the header it read two cycles back
    clear_only: assert property (@(posedge clk) disable iff (rst)
        (scan_req.en && scan_req.be != 8'h00) |->
            (scan_req.be == 8'h80 && scan_req.wdata == '0 &&
             scan_req.addr == $past(scan_req.addr, 2)))
        else begin
            $error("port B write with mask %h, nonzero data or not on the header read",
                   scan_req.be);
            fail_count++;
        end

    finish_single: assert property (@(posedge clk) disable iff (rst)
        finish.strobe |=> !finish.strobe)
        else begin
            $error("finish strobe held longer than one cycle");
            fail_count++;
        end

    done_follows: assert property (@(posedge clk) disable iff (rst)
        finish.strobe |=> (done.strobe && done.tid == $past(finish.tid)))
        else begin
            $error("done strobe or word missing one cycle after finish strobe");
            fail_count++;
        end

    count_grows: assert property (@(posedge clk) disable iff (rst)
        finished_count >= $past(finished_count))
        else begin
            $error("finished_count went down");
            fail_count++;
        end

endmodule

bind cmdout_unit cmdout_chk chk0 (
    .clk            (clk),
    .rst            (rst),
    .scan_req       (scan_req),
    .finish         (finish),
    .done           (done),
    .finished_count (finished_count)
);

//--- hw/cmdout_unit.sv
`timescale 1ns/1ps

module cmdout_unit #(
    parameter int NUM_ACCS = 16,
    parameter int SLOT_W = 6,
    parameter int MAX_TASKS = 256
) (
    input  logic                   clk,
    input  logic                   rst,
    input  cmdout_pkg::acc_write_t acc_wr,
    output cmdout_pkg::finish_t    done,
    output logic [31:0]            finished_count,
    output logic                   dup_error,
    output logic                   range_error
);

    import cmdout_pkg::*;

    mem_req_t          scan_req;
    logic [DATA_W-1:0] scan_rdata;
    finish_t           finish;

    // accelerators post on port A, the scanner owns port B
    cmdout_mem #(
        .NUM_ACCS (NUM_ACCS),
        .SLOT_W   (SLOT_W)
    ) u_mem (
        .clk     (clk),
        .a       (acc_wr),
        .b       (scan_req),
        .b_rdata (scan_rdata)
    );

    cmdout_scanner #(
        .NUM_ACCS (NUM_ACCS),
        .SLOT_W   (SLOT_W)
    ) u_scanner (
        .clk    (clk),
        .rst    (rst),
        .req    (scan_req),
        .rdata  (scan_rdata),
        .finish (finish)
    );

    finish_tracker #(
        .MAX_TASKS (MAX_TASKS)
    ) u_tracker (
        .clk            (clk),
        .rst            (rst),
        .finish         (finish),
        .done           (done),
        .finished_count (finished_count),
        .dup_error      (dup_error),
        .range_error    (range_error)
    );

endmodule

//--- hw/finish_tracker.sv
`timescale 1ns/1ps

module finish_tracker #(
    parameter int MAX_TASKS = 256
) (
    input  logic                clk,
    input  logic                rst,
    input  cmdout_pkg::finish_t finish,
    output cmdout_pkg::finish_t done,
    output logic [31:0]         finished_count,
    output logic                dup_error,
    output logic                range_error
);

    import cmdout_pkg::*;

    localparam int BIT_W = (MAX_TASKS > 1) ? $clog2(MAX_TASKS) : 1;
    localparam logic [TASK_IDX_W-1:0] IDX_LIMIT = TASK_IDX_W'(MAX_TASKS);

    logic [TASK_IDX_W-1:0] task_idx;
    logic                  in_range;
    logic                  seen;
    logic [MAX_TASKS-1:0]  finished_map;

    logic              done_strobe;
    logic [DATA_W-1:0] done_tid;

    // only the index is checked, the rest of the id is not known here
    assign task_idx = finish.tid[TASK_IDX_LSB +: TASK_IDX_W];
    assign in_range = (task_idx < IDX_LIMIT);
    assign seen = in_range && finished_map[task_idx[BIT_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            done_strobe <= 1'b0;
            finished_count <= '0;
            finished_map <= '0;
            dup_error <= 1'b0;
            range_error <= 1'b0;
        end else begin
            done_strobe <= finish.strobe;
            if (finish.strobe) begin
                if (!in_range) begin
                    range_error <= 1'b1;
                end else if (seen) begin
                    dup_error <= 1'b1;
                end else begin
                    finished_map[task_idx[BIT_W-1:0]] <= 1'b1;
                    finished_count <= finished_count + 32'd1;
                end
            end
        end
    end

    // the reported word passes through whether or not it was accepted
    always_ff @(posedge clk) begin
        if (finish.strobe) begin
            done_tid <= finish.tid;
        end
    end

    assign done.strobe = done_strobe;
    assign done.tid = done_tid;

endmodule

//--- hw/cmdout_scanner.sv
`timescale 1ns/1ps

module cmdout_scanner #(
    parameter int NUM_ACCS = 16,
    parameter int SLOT_W = 6
) (
    input  logic                          clk,
    input  logic                          rst,
    output cmdout_pkg::mem_req_t          req,
    input  logic [cmdout_pkg::DATA_W-1:0] rdata,
    output cmdout_pkg::finish_t           finish
);

    import cmdout_pkg::*;

    localparam int ACC_W = (NUM_ACCS > 1) ? $clog2(NUM_ACCS) : 1;
    localparam logic [ACC_W-1:0] LAST_ACC = ACC_W'(NUM_ACCS - 1);

    scan_state_t state;

    logic [ACC_W-1:0]  acc_id;
    logic [ACC_W-1:0]  next_acc;
    logic [SLOT_W-1:0] slot_idx [NUM_ACCS];
    logic [SLOT_W-1:0] cur_slot;
    logic [SLOT_W-1:0] addr_slot;
    logic              hit;

    assign cur_slot = slot_idx[acc_id];
    assign next_acc = (acc_id == LAST_ACC) ? '0 : acc_id + 1'b1;

    // only meaningful in READ_VALID, where rdata holds the header word
    assign hit = (rdata[VALID_LSB +: 8] == VALID_MARK);

    // on a hit the task-id word at slot+1 is requested right away
    always_comb begin
        addr_slot = cur_slot;
        if (state == READ_VALID && hit) begin
            addr_slot = cur_slot + 1'b1;
        end
    end

    // in READ_TID the address is back on the header, so the masked
    // write clears just its valid byte
    always_comb begin
        req.en = 1'b1;
        req.be = (state == READ_TID) ? VALID_BYTE_MASK : 8'h00;
        req.addr = ADDR_W'({acc_id, addr_slot});
        req.wdata = '0;
    end

    assign finish.strobe = (state == READ_TID);
    assign finish.tid = rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ISSUE_READ;
            acc_id <= '0;
            for (int i = 0; i < NUM_ACCS; i++) begin
                slot_idx[i] <= '0;
            end
        end else begin
            case (state)
                ISSUE_READ: begin
                    state <= READ_VALID;
                end

                READ_VALID: begin
                    if (hit) begin
                        state <= READ_TID;
                    end else begin
                        state <= ISSUE_READ;
                        acc_id <= next_acc;
                    end
                end

                READ_TID: begin
                    // stay on this ring and look at its next entry
                    state <= ISSUE_READ;
                    slot_idx[acc_id] <= cur_slot + SLOT_W'(2);
                end

                default: begin
                    state <= ISSUE_READ;
                end
            endcase
        end
    end

endmodule

//--- hw/cmdout_mem.sv
`timescale 1ns/1ps

module cmdout_mem #(
    parameter int NUM_ACCS = 16,
    parameter int SLOT_W = 6
) (
    input  logic                          clk,
    input  cmdout_pkg::acc_write_t        a,
    input  cmdout_pkg::mem_req_t          b,
    output logic [cmdout_pkg::DATA_W-1:0] b_rdata
);

    import cmdout_pkg::*;

    localparam int ACC_W = (NUM_ACCS > 1) ? $clog2(NUM_ACCS) : 1;
    localparam int WORD_AW = ACC_W + SLOT_W;
    localparam int DEPTH = NUM_ACCS << SLOT_W;
    localparam int NUM_BYTES = DATA_W / 8;

    // one ring of 2**SLOT_W words per accelerator, ring number on top
    logic [DATA_W-1:0] mem [DEPTH];

    logic [WORD_AW-1:0] a_word;
    logic [WORD_AW-1:0] b_word;

    assign a_word = a.addr[WORD_AW-1:0];
    assign b_word = b.addr[WORD_AW-1:0];

    always_ff @(posedge clk) begin
        if (b.en) begin
            for (int i = 0; i < NUM_BYTES; i++) begin
                if (b.be[i]) begin
                    mem[b_word][i*8 +: 8] <= b.wdata[i*8 +: 8];
                end
            end
            // read returns the word as it was before this cycle's writes
            b_rdata <= mem[b_word];
        end
        // port A is assigned last so its bytes win on a same-word collision
        if (a.strobe) begin
            mem[a_word] <= a.data;
        end
    end

endmodule

//--- hw/cmdout_pkg.sv
package cmdout_pkg;

    // memory word and word address widths
    localparam int DATA_W = 64;
    localparam int ADDR_W = 12;

    // header top byte that marks an entry as ready to be collected
    localparam logic [7:0] VALID_MARK = 8'h80;
    localparam int VALID_LSB = 56;
    localparam logic [7:0] VALID_BYTE_MASK = 8'h80;

    // task index field inside the task-id word, bits 55..32
    localparam int TASK_IDX_W = 24;
    localparam int TASK_IDX_LSB = 32;

    typedef struct packed {
        logic              en;
        logic [7:0]        be;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              strobe;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } acc_write_t;

    typedef struct packed {
        logic              strobe;
        logic [DATA_W-1:0] tid;
    } finish_t;

    typedef enum logic [1:0] {
        ISSUE_READ,
        READ_VALID,
        READ_TID
    } scan_state_t;

endpackage
